// File: dv/tb_eth_st_monitor.sv
/* Sends random Avalon-ST frames to the monitor and checks its registers over Wishbone.
   Buffer words past the last beat of a frame are not checked because the buffer has no reset. */
`timescale 1ns/1ns
`default_nettype none

module tb_eth_st_monitor;

    localparam int st_error_w = 1;
    localparam int cap_beats  = 16;
    localparam int len_w      = 16;
    localparam int clk_period = 100;
    // Run budget in stream beats and host accesses
    localparam int max_beats       = 320;
    localparam int max_accesses    = 80;
    localparam int watchdog_cycles = 16 + (max_beats + max_accesses) * 4;
    localparam int first_len       = 61;
    localparam int long_len        = 150;

    logic                  clk;
    logic                  reset;
    logic                  startofpacket;
    logic                  endofpacket;
    logic                  valid;
    logic                  ready;
    logic [63:0]           data;
    logic [2:0]            empty;
    logic [st_error_w-1:0] error;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [7:0]            wb_adr;
    logic [31:0]           wb_dat_w;
    wire  [31:0]           wb_dat_r;
    wire                   wb_ack;

    // Sent frames, one entry per frame or orphan beat
    logic [7:0] sent_bytes [$];
    int         fr_off  [$];
    int         fr_len  [$];
    bit         fr_err  [$];
    bit         fr_drop [$];
    int         fr_viol [$];
    // First entry seen after the last clear and the last rearm
    int clear_from = 0;
    int rearm_from = 0;

    logic [31:0] rng_state = 32'h6f3f;
    int groups_sent    = 0;
    int groups_checked = 0;
    int n_checks       = 0;
    int n_value_err    = 0;
    int n_other_err    = 0;

    eth_st_monitor_top #(
        .st_error_w(st_error_w),
        .cap_beats(cap_beats),
        .len_w(len_w)
    ) u_dut (
        .clk(clk), .reset(reset),
        .startofpacket(startofpacket), .endofpacket(endofpacket),
        .valid(valid), .ready(ready), .data(data), .empty(empty), .error(error),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Expected register word from the list of sent frames
    function automatic logic [31:0] ref_word(input logic [7:0] adr);
        logic [31:0] frames;
        logic [31:0] bytes;
        logic [31:0] err_frames;
        logic [31:0] violations;
        logic [31:0] word;
        int          cap;
        int          off;
        int          b;
        int          i;
        int          j;
        frames     = '0;
        bytes      = '0;
        err_frames = '0;
        violations = '0;
        word       = '0;
        cap        = -1;
        // Dropped frames and orphans only add violations
        for (i = clear_from; i < fr_len.size(); i++) begin
            violations = violations + 32'(fr_viol[i]);
            if (!fr_drop[i]) begin
                frames = frames + 32'd1;
                bytes  = bytes + 32'(fr_len[i]);
                if (fr_err[i]) begin
                    err_frames = err_frames + 32'd1;
                end
            end
        end
        // Capture holds the first clean frame since rearm
        for (i = rearm_from; i < fr_len.size(); i++) begin
            if (cap < 0 && !fr_drop[i] && !fr_err[i]) begin
                cap = i;
            end
        end
        off = int'(adr) - int'(eth_mon_pkg::cap_base);
        case (adr)
            eth_mon_pkg::reg_frames:     word = frames;
            eth_mon_pkg::reg_bytes:      word = bytes;
            eth_mon_pkg::reg_err_frames: word = err_frames;
            eth_mon_pkg::reg_violations: word = violations;
            eth_mon_pkg::reg_cap_status: begin
                if (cap >= 0) begin
                    word[31]   = 1'b1;
                    word[30]   = (fr_len[cap] > cap_beats * 8);
                    word[15:0] = 16'(fr_len[cap]);
                end
            end
            default: begin
                if (cap >= 0 && off >= 0 && off < 2 * cap_beats) begin
                    // Word k holds bytes 4k to 4k+3, first byte on top
                    for (j = 0; j < 4; j++) begin
                        b = off * 4 + j;
                        if (b < fr_len[cap]) begin
                            word[31 - 8*j -: 8] = sent_bytes[fr_off[cap] + b];
                        end
                    end
                end
            end
        endcase
        return word;
    endfunction

    task automatic next_random(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    // Holds one beat until valid and ready meet
    task automatic drive_beat(input logic sop, input logic eop, input logic [63:0] beat,
                              input logic [2:0] emp, input logic err);
        logic [31:0] r;
        do begin
            @(negedge clk);
            next_random(r);
            // Each side idles about one cycle in eight
            valid         = (r[2:0] != 3'd0);
            ready         = (r[5:3] != 3'd0);
            startofpacket = sop;
            endofpacket   = eop;
            data          = beat;
            empty         = emp;
            error         = st_error_w'(err);
        end while (!(valid && ready));
    endtask

    // send_beats of 0 sends the whole frame, fewer leaves it open
    task automatic send_frame(input int len, input int err_beat, input int bad_empty_beat,
                              input int send_beats);
        int          nbeats;
        int          nsend;
        int          off;
        int          b;
        int          s;
        logic [31:0] r;
        logic [63:0] beat;
        logic [2:0]  emp;
        nbeats = (len + 7) / 8;
        nsend  = (send_beats > 0) ? send_beats : nbeats;
        off    = sent_bytes.size();
        for (b = 0; b < len; b++) begin
            next_random(r);
            sent_bytes.push_back(r[7:0]);
        end
        fr_off.push_back(off);
        fr_len.push_back(len);
        fr_err.push_back(err_beat >= 0);
        // Open frame gets flagged when the next start arrives
        fr_drop.push_back(nsend < nbeats);
        fr_viol.push_back(int'(nsend < nbeats) + int'(bad_empty_beat >= 0));
        for (b = 0; b < nsend; b++) begin
            beat = '0;
            for (s = 0; s < 8; s++) begin
                if (b * 8 + s < len) begin
                    beat[63 - 8*s -: 8] = sent_bytes[off + b * 8 + s];
                end
            end
            if (b == nbeats - 1) begin
                emp = 3'(nbeats * 8 - len);
            end else if (b == bad_empty_beat) begin
                emp = 3'd2;
            end else begin
                emp = 3'd0;
            end
            drive_beat(b == 0, b == nbeats - 1, beat, emp, b == err_beat);
        end
    endtask

    // Data beat with no frame open
    task automatic send_orphan();
        logic [31:0] r;
        next_random(r);
        fr_off.push_back(sent_bytes.size());
        fr_len.push_back(0);
        fr_err.push_back(1'b0);
        fr_drop.push_back(1'b1);
        fr_viol.push_back(1);
        drive_beat(1'b0, 1'b0, {r, r}, 3'd0, 1'b0);
    endtask

    task automatic hand_off(input int n);
        @(negedge clk);
        valid         = 1'b0;
        startofpacket = 1'b0;
        endofpacket   = 1'b0;
        // Two cycles from the last beat to visible status
        repeat (2) @(negedge clk);
        groups_sent = n;
        wait (groups_checked == n);
    endtask

    task automatic wb_access(input logic we, input logic [7:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack && waited < 8);
        if (!wb_ack) begin
            n_other_err++;
            $display("No Wishbone ack for address %0d within 8 cycles", adr);
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic control_write(input int bit_pos);
        logic [31:0] unused_rd;
        wb_access(1'b1, eth_mon_pkg::reg_control, 32'd1 << bit_pos, unused_rd);
        // Command pulse acts one cycle after ack
        repeat (2) @(negedge clk);
    endtask

    task automatic check_reg(input string name, input logic [7:0] adr);
        logic [31:0] act;
        logic [31:0] exp;
        wb_access(1'b0, adr, 32'd0, act);
        exp = ref_word(adr);
        n_checks++;
        if (act !== exp) begin
            n_value_err++;
            $display("ERROR %s adr %0d: expected %h, actual %h", name, adr, exp, act);
        end
    endtask

    task automatic check_counters(input string name);
        check_reg(name, eth_mon_pkg::reg_frames);
        check_reg(name, eth_mon_pkg::reg_bytes);
        check_reg(name, eth_mon_pkg::reg_err_frames);
        check_reg(name, eth_mon_pkg::reg_violations);
    endtask

    task automatic check_buffer(input string name, input int nbytes);
        int nbeats;
        int w;
        nbeats = (nbytes + 7) / 8;
        if (nbeats > cap_beats) begin
            nbeats = cap_beats;
        end
        for (w = 0; w < 2 * nbeats; w++) begin
            check_reg(name, 8'(int'(eth_mon_pkg::cap_base) + w));
        end
    endtask

    initial begin : stream_driver
        int          i;
        int          len;
        logic [31:0] r;
        reset         = 1'b1;
        startofpacket = 1'b0;
        endofpacket   = 1'b0;
        valid         = 1'b0;
        ready         = 1'b0;
        data          = '0;
        empty         = '0;
        error         = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Good frames, every empty value, first one captured
        send_frame(first_len, -1, -1, 0);
        for (i = 1; i <= 8; i++) begin
            send_frame(i, -1, -1, 0);
        end
        for (i = 0; i < 16; i++) begin
            next_random(r);
            send_frame(int'(r % 100) + 1, -1, -1, 0);
        end
        hand_off(1);

        // Error raised on one random beat
        for (i = 0; i < 4; i++) begin
            next_random(r);
            len = int'(r % 100) + 1;
            next_random(r);
            send_frame(len, int'(r % 32'((len + 7) / 8)), -1, 0);
        end
        hand_off(2);

        // Orphan beat, start inside a frame, nonzero empty mid-frame
        send_orphan();
        send_frame(60, -1, -1, 3);
        send_frame(40, -1, -1, 0);
        send_frame(48, -1, 2, 0);
        hand_off(3);

        // After rearm an errored frame leaves the capture armed
        send_frame(20, 1, -1, 0);
        hand_off(4);
        send_frame(long_len, -1, -1, 0);
        hand_off(5);
    end

    initial begin : host_compare
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wait (groups_sent == 1);
        check_counters("good_frames");
        groups_checked = 1;
        wait (groups_sent == 2);
        check_counters("errored_frames");
        groups_checked = 2;
        wait (groups_sent == 3);
        check_counters("violations");
        // Buffer must still hold the first frame
        check_reg("first_capture", eth_mon_pkg::reg_cap_status);
        check_buffer("first_capture", first_len);
        control_write(eth_mon_pkg::ctl_rearm_bit);
        rearm_from = fr_len.size();
        groups_checked = 3;
        wait (groups_sent == 4);
        check_reg("errored_not_captured", eth_mon_pkg::reg_cap_status);
        groups_checked = 4;
        wait (groups_sent == 5);
        check_reg("long_capture", eth_mon_pkg::reg_cap_status);
        check_buffer("long_capture", long_len);
        control_write(eth_mon_pkg::ctl_clear_bit);
        clear_from = fr_len.size();
        check_counters("clear_stats");
        check_reg("clear_stats", eth_mon_pkg::reg_cap_status);

        $display("Summary: %0d checks, %0d value errors, %0d other errors",
                 n_checks, n_value_err, n_other_err);
        if (n_value_err == 0 && n_other_err == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin : watchdog
        #(watchdog_cycles * clk_period);
        $display("Run did not finish within %0d cycles", watchdog_cycles);
        $display("Summary: %0d checks, %0d value errors, %0d other errors",
                 n_checks, n_value_err, n_other_err + 1);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: eth_st_monitor.f
verilog/eth_mon_pkg.sv
verilog/st_frame_checker.sv
verilog/st_frame_capture.sv
verilog/st_frame_stats.sv
verilog/wb_mon_csr.sv
verilog/eth_st_monitor_top.sv
dv/tb_eth_st_monitor.sv

// File: run.sh
#!/bin/sh
# Build and run the monitor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_eth_st_monitor \
    -f eth_st_monitor.f \
    -o tb_eth_st_monitor

out=$(./obj_dir/tb_eth_st_monitor)
echo "$out"

if echo "$out" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1

// File: verilog/eth_mon_pkg.sv
/* Widths and register map shared by the stream monitor blocks.
   Stream beats are 8 byte symbols, first byte in the top symbol. */
`default_nettype none

package eth_mon_pkg;

    // Avalon-ST tap geometry
    localparam int st_symbol_w    = 8;
    localparam int st_num_symbols = 8;
    localparam int st_data_w      = st_symbol_w * st_num_symbols;
    localparam int st_empty_w     = 3;

    // Wishbone host side
    localparam int wb_data_w = 32;
    localparam int wb_addr_w = 8;

    // Checker framing state
    typedef enum logic {
        idle,
        in_frame
    } frame_state_t;

    // Host word addresses
    typedef enum logic [wb_addr_w-1:0] {
        reg_frames     = 8'd0,
        reg_bytes      = 8'd1,
        reg_err_frames = 8'd2,
        reg_violations = 8'd3,
        reg_cap_status = 8'd4,
        reg_control    = 8'd5,
        // Buffer window, two words per beat
        cap_base       = 8'd64
    } csr_addr_t;

    // Control write bits
    localparam int ctl_clear_bit = 0;
    localparam int ctl_rearm_bit = 1;

endpackage

`default_nettype wire

// File: verilog/eth_st_monitor_top.sv
/* Passive Avalon-ST Ethernet monitor with a Wishbone register port. ready is only
   observed; nothing is driven back onto the stream. */
`timescale 1ns/1ns
`default_nettype none

module eth_st_monitor_top #(
    parameter int st_error_w = 1,
    parameter int cap_beats  = 16,
    parameter int len_w      = 16
) (
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               startofpacket,
    input  wire                               endofpacket,
    input  wire                               valid,
    input  wire                               ready,
    input  wire [eth_mon_pkg::st_data_w-1:0]  data,
    input  wire [eth_mon_pkg::st_empty_w-1:0] empty,
    input  wire [st_error_w-1:0]              error,
    input  wire                               wb_cyc,
    input  wire                               wb_stb,
    input  wire                               wb_we,
    input  wire [eth_mon_pkg::wb_addr_w-1:0]  wb_adr,
    input  wire [eth_mon_pkg::wb_data_w-1:0]  wb_dat_w,
    output wire [eth_mon_pkg::wb_data_w-1:0]  wb_dat_r,
    output wire                               wb_ack
);

    // Checker to capture and stats
    wire                              beat_we;
    wire [len_w-1:0]                  beat_idx;
    wire [eth_mon_pkg::st_data_w-1:0] beat_data;
    wire                              frame_start;
    wire                              frame_done;
    wire [len_w-1:0]                  frame_len;
    wire                              frame_err;
    wire                              violation;

    // Host commands
    wire                              clear_stats;
    wire                              rearm;

    // Capture read port and status
    wire [$clog2(cap_beats)-1:0]      rd_beat;
    wire [eth_mon_pkg::st_data_w-1:0] rd_data;
    wire                              cap_valid;
    wire                              cap_trunc;
    wire [len_w-1:0]                  cap_len;

    // Counters
    wire [eth_mon_pkg::wb_data_w-1:0] frames;
    wire [eth_mon_pkg::wb_data_w-1:0] bytes;
    wire [eth_mon_pkg::wb_data_w-1:0] err_frames;
    wire [eth_mon_pkg::wb_data_w-1:0] violations;

    st_frame_checker #(.st_error_w(st_error_w), .len_w(len_w)) u_checker (
        .clk(clk), .reset(reset),
        .startofpacket(startofpacket), .endofpacket(endofpacket),
        .valid(valid), .ready(ready), .data(data), .empty(empty), .error(error),
        .beat_we(beat_we), .beat_idx(beat_idx), .beat_data(beat_data),
        .frame_start(frame_start), .frame_done(frame_done),
        .frame_len(frame_len), .frame_err(frame_err), .violation(violation)
    );

    st_frame_capture #(.cap_beats(cap_beats), .len_w(len_w)) u_capture (
        .clk(clk), .reset(reset),
        .beat_we(beat_we), .beat_idx(beat_idx), .beat_data(beat_data),
        .frame_start(frame_start), .frame_done(frame_done),
        .frame_len(frame_len), .frame_err(frame_err), .rearm(rearm),
        .rd_beat(rd_beat), .rd_data(rd_data),
        .cap_valid(cap_valid), .cap_trunc(cap_trunc), .cap_len(cap_len)
    );

    st_frame_stats #(.len_w(len_w)) u_stats (
        .clk(clk), .reset(reset),
        .frame_done(frame_done), .frame_len(frame_len), .frame_err(frame_err),
        .violation(violation), .clear_stats(clear_stats),
        .frames(frames), .bytes(bytes), .err_frames(err_frames), .violations(violations)
    );

    wb_mon_csr #(.cap_beats(cap_beats), .len_w(len_w)) u_csr (
        .clk(clk), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
        .frames(frames), .bytes(bytes), .err_frames(err_frames), .violations(violations),
        .cap_valid(cap_valid), .cap_trunc(cap_trunc), .cap_len(cap_len),
        .rd_data(rd_data), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .clear_stats(clear_stats), .rearm(rearm), .rd_beat(rd_beat)
    );

endmodule

`default_nettype wire

// File: verilog/st_frame_capture.sv
/* Holds the first good frame after arming until rearm. cap_beats must be a power of
   two up to 32; beats past the buffer are dropped and flagged as truncation. */
`timescale 1ns/1ns
`default_nettype none

module st_frame_capture #(
    parameter int  cap_beats = 16,
    parameter int  len_w     = 16,
    localparam int idx_w     = $clog2(cap_beats)
) (
    input  wire                                clk,
    input  wire                                reset,
    input  wire                                beat_we,
    input  wire [len_w-1:0]                    beat_idx,
    input  wire [eth_mon_pkg::st_data_w-1:0]   beat_data,
    input  wire                                frame_start,
    input  wire                                frame_done,
    input  wire [len_w-1:0]                    frame_len,
    input  wire                                frame_err,
    input  wire                                rearm,
    input  wire [idx_w-1:0]                    rd_beat,
    output logic [eth_mon_pkg::st_data_w-1:0]  rd_data,
    output logic                               cap_valid,
    output logic                               cap_trunc,
    output logic [len_w-1:0]                   cap_len
);

    localparam int cap_bytes = cap_beats * eth_mon_pkg::st_num_symbols;

    typedef enum logic [1:0] {
        cap_armed,
        cap_filling,
        cap_held
    } cap_state_t;

    cap_state_t state;
    logic [eth_mon_pkg::st_data_w-1:0] mem [cap_beats];

    logic owns_frame;
    logic mem_we;
    logic frame_end;

    // Frame belongs to us if it starts now or is already being filled
    assign owns_frame = (state != cap_held) && (frame_start || state == cap_filling);
    assign mem_we     = beat_we && owns_frame && (beat_idx < len_w'(cap_beats));
    assign frame_end  = owns_frame && frame_done;
    assign cap_valid  = (state == cap_held);
    assign rd_data    = mem[rd_beat];

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[beat_idx[idx_w-1:0]] <= beat_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= cap_armed;
            cap_trunc <= 1'b0;
            cap_len   <= '0;
        end else if (rearm) begin
            state     <= cap_armed;
            cap_trunc <= 1'b0;
            cap_len   <= '0;
        end else if (frame_end) begin
            if (frame_err) begin
                // Errored frame, wait for the next one
                state <= cap_armed;
            end else begin
                state     <= cap_held;
                cap_len   <= frame_len;
                cap_trunc <= frame_len > len_w'(cap_bytes);
            end
        end else if (frame_start && state != cap_held) begin
            // Also restarts after a dropped frame
            state <= cap_filling;
        end
    end

    // Buffer stays frozen while held and not rearmed
    a_frozen: assert property (@(posedge clk) disable iff (reset)
        cap_valid && !rearm |=> !mem_we);

    // Capture only completes on a clean frame end
    a_good_end: assert property (@(posedge clk) disable iff (reset)
        $rose(cap_valid) |-> $past(frame_done && !frame_err));

endmodule

`default_nettype wire

// File: verilog/st_frame_checker.sv
/* Passive framing checker; a beat counts only with valid and ready high.
   Lengths wrap at len_w bits, and a dropped frame gives no frame_done. */
`timescale 1ns/1ns
`default_nettype none

module st_frame_checker #(
    parameter int st_error_w = 1,
    parameter int len_w      = 16
) (
    input  wire                                clk,
    input  wire                                reset,
    input  wire                                startofpacket,
    input  wire                                endofpacket,
    input  wire                                valid,
    input  wire                                ready,
    input  wire [eth_mon_pkg::st_data_w-1:0]   data,
    input  wire [eth_mon_pkg::st_empty_w-1:0]  empty,
    input  wire [st_error_w-1:0]               error,
    output logic                               beat_we,
    output logic [len_w-1:0]                   beat_idx,
    output logic [eth_mon_pkg::st_data_w-1:0]  beat_data,
    output logic                               frame_start,
    output logic                               frame_done,
    output logic [len_w-1:0]                   frame_len,
    output logic                               frame_err,
    output logic                               violation
);

    eth_mon_pkg::frame_state_t state;
    logic [len_w-1:0] beat_cnt;
    logic [len_w-1:0] len_acc;
    logic             err_acc;

    logic             accept;
    logic             beat_err;
    logic             mid_empty;
    logic [len_w-1:0] beat_bytes;

    assign accept    = valid && ready;
    assign beat_err  = |error;
    // Empty only means something on the last beat
    assign mid_empty = !endofpacket && (empty != '0);
    assign beat_bytes = endofpacket ?
        len_w'(eth_mon_pkg::st_num_symbols) - len_w'(empty) :
        len_w'(eth_mon_pkg::st_num_symbols);

    // Beat payload follows the tap by one cycle
    always_ff @(posedge clk) begin
        beat_data <= data;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= eth_mon_pkg::idle;
            beat_cnt    <= '0;
            len_acc     <= '0;
            err_acc     <= 1'b0;
            beat_we     <= 1'b0;
            beat_idx    <= '0;
            frame_start <= 1'b0;
            frame_done  <= 1'b0;
            frame_len   <= '0;
            frame_err   <= 1'b0;
            violation   <= 1'b0;
        end else begin
            // Pulses default low
            beat_we     <= 1'b0;
            frame_start <= 1'b0;
            frame_done  <= 1'b0;
            violation   <= 1'b0;
            if (accept) begin
                if (startofpacket) begin
                    // Start inside a frame drops the old one silently
                    violation   <= (state == eth_mon_pkg::in_frame) || mid_empty;
                    beat_we     <= 1'b1;
                    beat_idx    <= '0;
                    frame_start <= 1'b1;
                    beat_cnt    <= len_w'(1);
                    len_acc     <= beat_bytes;
                    err_acc     <= beat_err;
                    if (endofpacket) begin
                        // One-beat frame
                        frame_done <= 1'b1;
                        frame_len  <= beat_bytes;
                        frame_err  <= beat_err;
                        state      <= eth_mon_pkg::idle;
                    end else begin
                        state <= eth_mon_pkg::in_frame;
                    end
                end else if (state == eth_mon_pkg::idle) begin
                    // Orphan beat, flagged and ignored
                    violation <= 1'b1;
                end else begin
                    violation <= mid_empty;
                    beat_we   <= 1'b1;
                    beat_idx  <= beat_cnt;
                    beat_cnt  <= beat_cnt + 1'b1;
                    len_acc   <= len_acc + beat_bytes;
                    err_acc   <= err_acc | beat_err;
                    if (endofpacket) begin
                        frame_done <= 1'b1;
                        frame_len  <= len_acc + beat_bytes;
                        frame_err  <= err_acc | beat_err;
                        state      <= eth_mon_pkg::idle;
                    end
                end
            end
        end
    end

    // Orphan beats give a violation only, never a frame or a buffer write
    a_orphan: assert property (@(posedge clk) disable iff (reset)
        accept && !startofpacket && state == eth_mon_pkg::idle
        |=> violation && !frame_done && !beat_we);

    // Every buffer write comes from a beat that belonged to a frame
    a_beat_src: assert property (@(posedge clk) disable iff (reset)
        beat_we |-> $past(accept && (startofpacket || state == eth_mon_pkg::in_frame)));

endmodule

`default_nettype wire

// File: verilog/st_frame_stats.sv
/* Saturating 32-bit event counters; clear_stats wins over a same-cycle event */
`timescale 1ns/1ns
`default_nettype none

module st_frame_stats #(
    parameter int len_w = 16
) (
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               frame_done,
    input  wire [len_w-1:0]                   frame_len,
    input  wire                               frame_err,
    input  wire                               violation,
    input  wire                               clear_stats,
    output logic [eth_mon_pkg::wb_data_w-1:0] frames,
    output logic [eth_mon_pkg::wb_data_w-1:0] bytes,
    output logic [eth_mon_pkg::wb_data_w-1:0] err_frames,
    output logic [eth_mon_pkg::wb_data_w-1:0] violations
);

    localparam int cw = eth_mon_pkg::wb_data_w;

    // Extra bit catches the byte counter overflow
    logic [cw:0] bytes_sum;

    assign bytes_sum = {1'b0, bytes} + (cw + 1)'(frame_len);

    function automatic logic [cw-1:0] sat_inc(input logic [cw-1:0] cnt);
        return (cnt == '1) ? cnt : cnt + 1'b1;
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            frames     <= '0;
            bytes      <= '0;
            err_frames <= '0;
            violations <= '0;
        end else if (clear_stats) begin
            frames     <= '0;
            bytes      <= '0;
            err_frames <= '0;
            violations <= '0;
        end else begin
            if (frame_done) begin
                frames <= sat_inc(frames);
                bytes  <= bytes_sum[cw] ? '1 : bytes_sum[cw-1:0];
                if (frame_err) begin
                    err_frames <= sat_inc(err_frames);
                end
            end
            // Violations are independent of frame completion
            if (violation) begin
                violations <= sat_inc(violations);
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/wb_mon_csr.sv
/* Wishbone classic slave, ack one clock after stb, read data valid with ack.
   Control register reads zero; unmapped words read zero. */
`timescale 1ns/1ns
`default_nettype none

module wb_mon_csr #(
    parameter int  cap_beats = 16,
    parameter int  len_w     = 16,
    localparam int idx_w     = $clog2(cap_beats)
) (
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               wb_cyc,
    input  wire                               wb_stb,
    input  wire                               wb_we,
    input  wire [eth_mon_pkg::wb_addr_w-1:0]  wb_adr,
    input  wire [eth_mon_pkg::wb_data_w-1:0]  wb_dat_w,
    input  wire [eth_mon_pkg::wb_data_w-1:0]  frames,
    input  wire [eth_mon_pkg::wb_data_w-1:0]  bytes,
    input  wire [eth_mon_pkg::wb_data_w-1:0]  err_frames,
    input  wire [eth_mon_pkg::wb_data_w-1:0]  violations,
    input  wire                               cap_valid,
    input  wire                               cap_trunc,
    input  wire [len_w-1:0]                   cap_len,
    input  wire [eth_mon_pkg::st_data_w-1:0]  rd_data,
    output logic [eth_mon_pkg::wb_data_w-1:0] wb_dat_r,
    output logic                              wb_ack,
    output logic                              clear_stats,
    output logic                              rearm,
    output logic [idx_w-1:0]                  rd_beat
);

    logic                              access;
    logic                              ctl_write;
    logic                              in_window;
    logic [eth_mon_pkg::wb_addr_w-1:0] win_off;
    logic [eth_mon_pkg::wb_data_w-1:0] status;
    logic [eth_mon_pkg::wb_data_w-1:0] rd_word;

    // New cycle only when ack is not already up
    assign access    = wb_cyc && wb_stb && !wb_ack;
    assign ctl_write = access && wb_we && (wb_adr == eth_mon_pkg::reg_control);

    // Two words per beat, upper half first
    assign win_off   = wb_adr - eth_mon_pkg::cap_base;
    assign in_window = (wb_adr >= eth_mon_pkg::cap_base) && (win_off < 8'(2 * cap_beats));
    assign rd_beat   = win_off[idx_w:1];

    always_comb begin
        status        = '0;
        status[31]    = cap_valid;
        status[30]    = cap_trunc;
        status[15:0]  = 16'(cap_len);
    end

    always_comb begin
        rd_word = '0;
        case (wb_adr)
            eth_mon_pkg::reg_frames:     rd_word = frames;
            eth_mon_pkg::reg_bytes:      rd_word = bytes;
            eth_mon_pkg::reg_err_frames: rd_word = err_frames;
            eth_mon_pkg::reg_violations: rd_word = violations;
            eth_mon_pkg::reg_cap_status: rd_word = status;
            default: begin
                if (in_window) begin
                    rd_word = win_off[0] ? rd_data[31:0] : rd_data[63:32];
                end
            end
        endcase
    end

    // Read data sampled together with ack
    always_ff @(posedge clk) begin
        if (access) begin
            wb_dat_r <= rd_word;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_ack      <= 1'b0;
            clear_stats <= 1'b0;
            rearm       <= 1'b0;
        end else begin
            wb_ack      <= access;
            clear_stats <= ctl_write && wb_dat_w[eth_mon_pkg::ctl_clear_bit];
            rearm       <= ctl_write && wb_dat_w[eth_mon_pkg::ctl_rearm_bit];
        end
    end

    // One ack per access
    a_ack_single: assert property (@(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack);

endmodule

`default_nettype wire
